// File: decode_top.f
+incdir+source
source/decode_pkg.sv
source/rv_imm_gen.sv
source/rv_ctrl_decode.sv
source/rv_op_decode.sv
source/decode_top.sv
tests/decode_chk.sv
tests/tb_decode_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_decode_top \
   -f decode_top.f \
   -o Vtb_decode_top

./obj_dir/Vtb_decode_top 2>&1 | tee sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation did not pass, see sim.log"
   exit 1
fi

// File: tests/tb_decode_top.sv
`timescale 1ns/10ps

module tb_decode_top;

   localparam int TEST_LEN   = 200;
   localparam int MAX_CYCLES = 8 * TEST_LEN + 400; // six tests, gaps and drain

   logic               clk;
   logic               rst_n;
   logic               fetch_valid;
   decode_pkg::fetch_t fetch;
   logic               uop_valid;
   decode_pkg::uop_t   uop;

   integer             seed = 61;
   int                 errors = 0;
   int                 checks = 0;
   int                 cycles = 0;
   int                 test_num = 0;
   int                 err_mark = 0;
   int                 chk_mark = 0;
   logic               armed = 1'b0;
   logic               exp_v = 1'b0;
   decode_pkg::uop_t   exp_q[$];
   decode_pkg::uop_t   want;

   decode_top UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch       (fetch),
      .uop_valid   (uop_valid),
      .uop         (uop)
   );

   bind decode_top decode_chk u_chk (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .uop_valid   (uop_valid),
      .uop         (uop)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int unsigned pick(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // reference decode of one fetched word
   function automatic decode_pkg::uop_t predict_uop(input decode_pkg::fetch_t f);
      decode_pkg::uop_t u;
      logic [31:0]      w;
      logic [6:0]       f7;
      logic [2:0]       f3;
      logic [5:0]       rd;
      logic [5:0]       rs1;
      logic [5:0]       rs2;
      logic [63:0]      imm_i;
      logic [63:0]      imm_s;
      logic [63:0]      imm_u;
      logic [63:0]      imm_b;
      logic [63:0]      imm_j;
      w = f.insn;
      f7 = w[31:25];
      f3 = w[14:12];
      rd = {1'b0, w[11:7]};
      rs1 = {1'b0, w[19:15]};
      rs2 = {1'b0, w[24:20]};
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
      imm_u = {{32{w[31]}}, w[31:12], 12'h000};
      imm_b = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      u = '0;
      u.op = decode_pkg::II;
      u.pc = f.pc;
      if (f.page_fault)
      begin
         u.op = decode_pkg::FETCH_PF;
         return u;
      end
      case (w[6:0])
         7'h03:
         begin
            u.dst = rd;
            u.dst_valid = (rd != 0);
            u.src_a = rs1;
            u.src_a_valid = 1'b1;
            u.is_mem = 1'b1;
            u.rvimm = imm_i;
            case (f3)
               3'd0: u.op = decode_pkg::LB;
               3'd1: u.op = decode_pkg::LH;
               3'd2: u.op = decode_pkg::LW;
               3'd3: u.op = decode_pkg::LD;
               3'd4: u.op = decode_pkg::LBU;
               3'd5: u.op = decode_pkg::LHU;
               3'd6: u.op = decode_pkg::LWU;
               default: ;
            endcase
         end
         7'h23:
         begin
            u.src_a = rs1;
            u.src_b = rs2;
            u.src_a_valid = 1'b1;
            u.src_b_valid = 1'b1;
            u.is_mem = 1'b1;
            u.is_store = 1'b1;
            u.rvimm = imm_s;
            case (f3)
               3'd0: u.op = decode_pkg::SB;
               3'd1: u.op = decode_pkg::SH;
               3'd2: u.op = decode_pkg::SW;
               3'd3: u.op = decode_pkg::SD;
               default: ;
            endcase
         end
         7'h13:
         begin
            u.dst = rd;
            u.src_a = rs1;
            u.dst_valid = (rd != 0);
            u.src_a_valid = (rd != 0);
            u.is_int = 1'b1;
            u.is_cheap_int = 1'b1;
            u.rvimm = imm_i;
            case (f3)
               3'd0: u.op = decode_pkg::ADDI;
               3'd1: u.op = decode_pkg::SLLI;
               3'd2: u.op = decode_pkg::SLTI;
               3'd3: u.op = decode_pkg::SLTIU;
               3'd4: u.op = decode_pkg::XORI;
               3'd5:
               begin
                  if (w[31:26] == 6'h00)
                     u.op = decode_pkg::SRLI;
                  else if (w[31:26] == 6'h10)
                     u.op = decode_pkg::SRAI;
               end
               3'd6: u.op = decode_pkg::ORI;
               default: u.op = decode_pkg::ANDI;
            endcase
            if (u.op != decode_pkg::II && rd == 0)
               u.op = decode_pkg::NOP;
         end
         7'h33:
         begin
            u.dst = rd;
            u.src_a = rs1;
            u.src_b = rs2;
            u.dst_valid = (rd != 0);
            u.src_a_valid = 1'b1;
            u.src_b_valid = 1'b1;
            u.is_int = 1'b1;
            case ({f7, f3})
               {7'h00, 3'd0}: u.op = decode_pkg::ADDU;
               {7'h20, 3'd0}: u.op = decode_pkg::SUBU;
               {7'h00, 3'd1}: u.op = decode_pkg::SLL;
               {7'h00, 3'd2}: u.op = decode_pkg::SLT;
               {7'h00, 3'd3}: u.op = decode_pkg::SLTU;
               {7'h00, 3'd4}: u.op = decode_pkg::XOR;
               {7'h00, 3'd5}: u.op = decode_pkg::SRL;
               {7'h20, 3'd5}: u.op = decode_pkg::SRA;
               {7'h00, 3'd6}: u.op = decode_pkg::OR;
               {7'h00, 3'd7}: u.op = decode_pkg::AND;
               {7'h01, 3'd0}: u.op = decode_pkg::MUL;
               {7'h01, 3'd1}: u.op = decode_pkg::MULH;
               {7'h01, 3'd3}: u.op = decode_pkg::MULHU;
               {7'h01, 3'd4}: u.op = decode_pkg::DIV;
               {7'h01, 3'd5}: u.op = decode_pkg::DIVU;
               {7'h01, 3'd6}: u.op = decode_pkg::REM;
               {7'h01, 3'd7}: u.op = decode_pkg::REMU;
               default: ;
            endcase
            u.is_cheap_int = !(u.op inside {decode_pkg::MUL, decode_pkg::MULH,
                                            decode_pkg::MULHU, decode_pkg::DIV,
                                            decode_pkg::DIVU, decode_pkg::REM,
                                            decode_pkg::REMU});
            if (u.op != decode_pkg::II && rd == 0)
               u.op = decode_pkg::NOP;
         end
         7'h37,
         7'h17:
         begin
            u.dst = rd;
            u.dst_valid = (rd != 0);
            u.is_int = 1'b1;
            u.is_cheap_int = 1'b1;
            u.op = (w[5] == 1'b1) ? decode_pkg::LUI : decode_pkg::AUIPC;
            u.rvimm = (w[5] == 1'b1) ? imm_u : f.pc + imm_u;
            if (rd == 0)
               u.op = decode_pkg::NOP;
         end
         7'h0f: u.op = decode_pkg::NOP; // fence
         7'h63:
         begin
            u.src_a = rs1;
            u.src_b = rs2;
            u.src_a_valid = 1'b1;
            u.src_b_valid = 1'b1;
            u.br_pred = f.pred;
            u.is_br = 1'b1;
            u.is_int = 1'b1;
            u.is_cheap_int = 1'b1;
            u.rvimm = f.pc + imm_b;
            case (f3)
               3'd0: u.op = decode_pkg::BEQ;
               3'd1: u.op = decode_pkg::BNE;
               3'd4: u.op = decode_pkg::BLT;
               3'd5: u.op = decode_pkg::BGE;
               3'd6: u.op = decode_pkg::BLTU;
               3'd7: u.op = decode_pkg::BGEU;
               default: ;
            endcase
         end
         7'h6f:
         begin
            u.br_pred = 1'b1;
            u.is_br = 1'b1;
            u.is_int = 1'b1;
            u.rvimm = f.pc + imm_j;
            u.op = decode_pkg::J;
            if (rd != 0)
            begin
               u.op = decode_pkg::JAL;
               u.dst = rd;
               u.dst_valid = 1'b1;
               u.is_cheap_int = 1'b1;
            end
         end
         7'h67:
         begin
            u.src_a = rs1;
            u.src_a_valid = 1'b1;
            u.br_pred = 1'b1;
            u.is_br = 1'b1;
            u.is_int = 1'b1;
            u.is_cheap_int = 1'b1;
            u.rvimm = imm_i;
            u.imm = f.pred_target[15:0];
            u.jmp_imm = f.pred_target[63:16];
            if (rd != 0)
            begin
               u.op = decode_pkg::JALR;
               u.dst = rd;
               u.dst_valid = 1'b1;
            end
            else if (rs1 == 6'd1 || rs1 == 6'd5)
               u.op = decode_pkg::RET;
            else
               u.op = decode_pkg::JR;
         end
         default: ;
      endcase
      if (u.op == decode_pkg::II)
      begin
         u = '0;
         u.op = decode_pkg::II;
         u.pc = f.pc;
      end
      return u;
   endfunction

   // random word of one class
   function automatic logic [31:0] make_word(input int unsigned cls);
      logic [31:0] w;
      w = $random(seed);
      case (cls)
         0:
         begin
            w[6:0] = 7'h13;
            if (w[14:12] == 3'd5 && pick(4) != 0)
               w[31:26] = (pick(2) == 1) ? 6'h10 : 6'h00;
         end
         1:
         begin
            w[6:0] = 7'h33;
            case (pick(4))
               0: w[31:25] = 7'h00;
               1: w[31:25] = 7'h01;
               2: w[31:25] = 7'h20;
               default: ; // mostly unused funct7
            endcase
         end
         2: w[6:0] = 7'h37;
         3: w[6:0] = 7'h17;
         4: w[6:0] = 7'h03;
         5:
         begin
            w[6:0] = 7'h23;
            if (pick(8) != 0)
               w[14] = 1'b0;
         end
         6: w[6:0] = 7'h63;
         7: w[6:0] = 7'h6f;
         8:
         begin
            w[6:0] = 7'h67;
            case (pick(4))
               0: w[19:15] = 5'd1;
               1: w[19:15] = 5'd5;
               default: ;
            endcase
         end
         9: w[6:0] = 7'h0f;
         default:
         begin
            case (pick(4))
               0: w[6:0] = 7'h73;
               1: w[6:0] = 7'h2f;
               2: w[6:0] = 7'h3b;
               default: w[6:0] = 7'h1b;
            endcase
         end
      endcase
      if (pick(5) == 0)
         w[11:7] = 5'd0;
      return w;
   endfunction

   task automatic send(input int unsigned cls, input logic pf);
      fetch.insn = make_word(cls);
      fetch.pc = {$random(seed), $random(seed)};
      fetch.page_fault = pf;
      fetch.pred = (pick(2) == 1);
      fetch.pred_target = {$random(seed), $random(seed)};
      fetch_valid = 1'b1;
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycle();
      fetch_valid = 1'b0;
      @(posedge clk);
      #1;
   endtask

   task automatic end_test(input string name);
      repeat (2) idle_cycle();
      test_num++;
      $display("test %0d %s: %0d checks, %0d errors", test_num, name,
               checks - chk_mark, errors - err_mark);
      chk_mark = checks;
      err_mark = errors;
   endtask

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %0t: %s got %h exp %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic compare_uop(input decode_pkg::uop_t got, input decode_pkg::uop_t exp);
      check_field("op", 64'(got.op), 64'(exp.op));
      check_field("src_a", 64'(got.src_a), 64'(exp.src_a));
      check_field("src_b", 64'(got.src_b), 64'(exp.src_b));
      check_field("dst", 64'(got.dst), 64'(exp.dst));
      check_field("src_a_valid", 64'(got.src_a_valid), 64'(exp.src_a_valid));
      check_field("src_b_valid", 64'(got.src_b_valid), 64'(exp.src_b_valid));
      check_field("dst_valid", 64'(got.dst_valid), 64'(exp.dst_valid));
      check_field("rvimm", got.rvimm, exp.rvimm);
      check_field("imm", 64'(got.imm), 64'(exp.imm));
      check_field("jmp_imm", 64'(got.jmp_imm), 64'(exp.jmp_imm));
      check_field("pc", got.pc, exp.pc);
      check_field("br_pred", 64'(got.br_pred), 64'(exp.br_pred));
      check_field("is_br", 64'(got.is_br), 64'(exp.is_br));
      check_field("is_int", 64'(got.is_int), 64'(exp.is_int));
      check_field("is_cheap_int", 64'(got.is_cheap_int), 64'(exp.is_cheap_int));
      check_field("is_mem", 64'(got.is_mem), 64'(exp.is_mem));
      check_field("is_store", 64'(got.is_store), 64'(exp.is_store));
   endtask

   // capture what the DUT samples on this edge
   always @(posedge clk)
   begin
      armed <= 1'b1;
      exp_v <= rst_n && fetch_valid;
      if (rst_n && fetch_valid)
         exp_q.push_back(predict_uop(fetch));
   end

   // outputs are settled mid cycle
   always @(negedge clk)
   begin
      if (armed)
      begin
         if (uop_valid !== exp_v)
         begin
            $display("[FAIL] %0t: uop_valid got %b exp %b", $time, uop_valid, exp_v);
            errors++;
         end
         if (exp_v && exp_q.size() != 0)
         begin
            want = exp_q.pop_front();
            checks++;
            compare_uop(uop, want);
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial
   begin
      rst_n = 1'b0;
      fetch_valid = 1'b1; // strobes held through reset must not reach the output
      fetch = '0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      fetch_valid = 1'b0;

      repeat (8) idle_cycle();
      for (int n = 0; n < TEST_LEN / 2; n++)
      begin
         if (pick(2) == 0)
            idle_cycle();
         send(pick(11), 1'b0);
      end
      end_test("reset and idle");

      for (int n = 0; n < TEST_LEN; n++)
         send(pick(4), 1'b0);
      end_test("integer ops");

      for (int n = 0; n < TEST_LEN; n++)
         send(4 + pick(2), 1'b0);
      end_test("memory ops");

      for (int n = 0; n < TEST_LEN; n++)
         send(6 + pick(3), 1'b0);
      end_test("control flow");

      for (int n = 0; n < TEST_LEN; n++)
      begin
         case (pick(4))
            0: send(pick(11), 1'b1);
            1: send(9, 1'b0);
            2: send(10, 1'b0);
            default: send(pick(9), 1'b0);
         endcase
      end
      end_test("faults and unknowns");

      for (int n = 0; n < TEST_LEN; n++)
         send(pick(11), (pick(16) == 0));
      end_test("streaming");

      $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               test_num, checks, errors, UUT.u_chk.fail_count);
      if (errors == 0 && UUT.u_chk.fail_count == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

// File: tests/decode_chk.sv
`timescale 1ns/10ps

module decode_chk (
   input logic             clk,
   input logic             rst_n,
   input logic             fetch_valid,
   input logic             uop_valid,
   input decode_pkg::uop_t uop
);

   int fail_count = 0;

   // output valid clears on a reset edge
   a_reset_clears: assert property (@(posedge clk) !rst_n |=> !uop_valid)
      else
      begin
         fail_count++;
         $error("uop_valid high in the cycle after reset");
      end

   // exactly one cycle from strobe to micro-op
   a_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> (uop_valid == $past(fetch_valid)))
      else
      begin
         fail_count++;
         $error("uop_valid does not follow fetch_valid of the previous cycle");
      end

   a_store_is_mem: assert property (@(posedge clk) disable iff (!rst_n)
      (uop_valid && uop.is_store) |-> uop.is_mem)
      else
      begin
         fail_count++;
         $error("store micro-op without is_mem");
      end

   // x0 is never a real destination
   a_dst_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
      (uop_valid && uop.dst_valid) |-> (uop.dst != '0))
      else
      begin
         fail_count++;
         $error("dst_valid set with dst equal to zero");
      end

endmodule

// File: source/decode_top.sv
`timescale 1ns/10ps

module decode_top (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               fetch_valid,
   input  decode_pkg::fetch_t fetch,
   output logic               uop_valid,
   output decode_pkg::uop_t   uop
);

   decode_pkg::uop_t     dec_uop;
   decode_pkg::uop_t     next_uop;
   decode_pkg::imm_fmt_e imm_fmt;
   decode_pkg::xlen_t    rvimm;

   rv_op_decode u_op_decode (
      .fetch   (fetch),
      .dec_uop (dec_uop),
      .imm_fmt (imm_fmt)
   );

   rv_imm_gen u_imm_gen (
      .insn    (fetch.insn),
      .pc      (fetch.pc),
      .imm_fmt (imm_fmt),
      .rvimm   (rvimm)
   );

   always_comb
   begin
      next_uop = dec_uop;
      next_uop.rvimm = rvimm; // immediate or branch target
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         uop_valid <= 1'b0;
      else
         uop_valid <= fetch_valid;
   end

   // payload loads only on a strobe
   always_ff @(posedge clk)
   begin
      if (fetch_valid)
         uop <= next_uop;
   end

endmodule

// File: source/rv_op_decode.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module rv_op_decode (
   input  decode_pkg::fetch_t   fetch,
   output decode_pkg::uop_t     dec_uop,
   output decode_pkg::imm_fmt_e imm_fmt
);

   decode_pkg::prf_idx_t rd;
   decode_pkg::prf_idx_t rs1;
   decode_pkg::prf_idx_t rs2;
   decode_pkg::uop_op_e  alu_op;
   decode_pkg::uop_t     def_uop;
   decode_pkg::uop_t     ctrl_uop;
   logic                 ctrl_hit;

   assign rd  = {{(`DEC_LG_PRF-5){1'b0}}, fetch.insn.r.rd};
   assign rs1 = {{(`DEC_LG_PRF-5){1'b0}}, fetch.insn.r.rs1};
   assign rs2 = {{(`DEC_LG_PRF-5){1'b0}}, fetch.insn.r.rs2};

   rv_ctrl_decode u_ctrl_decode (
      .insn        (fetch.insn),
      .pred        (fetch.pred),
      .pred_target (fetch.pred_target),
      .ctrl_hit    (ctrl_hit),
      .ctrl_uop    (ctrl_uop)
   );

   always_comb
   begin
      def_uop = '0;
      def_uop.op = fetch.page_fault ? decode_pkg::FETCH_PF : decode_pkg::II;
      def_uop.pc = fetch.pc;
   end

   always_comb
   begin
      dec_uop = def_uop;
      imm_fmt = decode_pkg::IMM_NONE;
      alu_op = decode_pkg::II;
      if (fetch.page_fault)
         dec_uop = def_uop; // word is not trusted
      else if (ctrl_hit)
      begin
         dec_uop = ctrl_uop;
         dec_uop.pc = fetch.pc;
         case (ctrl_uop.op)
            decode_pkg::J,
            decode_pkg::JAL:  imm_fmt = decode_pkg::IMM_PC_J;
            decode_pkg::JR,
            decode_pkg::JALR,
            decode_pkg::RET:  imm_fmt = decode_pkg::IMM_I;
            default:          imm_fmt = decode_pkg::IMM_PC_B;
         endcase
      end
      else
      begin
         case (fetch.insn.r.opcode)
            decode_pkg::OPC_LOAD:
            begin
               dec_uop.dst = rd;
               dec_uop.dst_valid = (rd != '0);
               dec_uop.src_a = rs1;
               dec_uop.src_a_valid = 1'b1;
               dec_uop.is_mem = 1'b1;
               imm_fmt = decode_pkg::IMM_I;
               case (fetch.insn.i.funct3)
                  3'd0: dec_uop.op = decode_pkg::LB;
                  3'd1: dec_uop.op = decode_pkg::LH;
                  3'd2: dec_uop.op = decode_pkg::LW;
                  3'd3: dec_uop.op = decode_pkg::LD;
                  3'd4: dec_uop.op = decode_pkg::LBU;
                  3'd5: dec_uop.op = decode_pkg::LHU;
                  3'd6: dec_uop.op = decode_pkg::LWU;
                  default: ;
               endcase
            end
            decode_pkg::OPC_STORE:
            begin
               dec_uop.src_a = rs1;
               dec_uop.src_b = rs2;
               dec_uop.src_a_valid = 1'b1;
               dec_uop.src_b_valid = 1'b1;
               dec_uop.is_mem = 1'b1;
               dec_uop.is_store = 1'b1;
               imm_fmt = decode_pkg::IMM_S;
               case (fetch.insn.s.funct3)
                  3'd0: dec_uop.op = decode_pkg::SB;
                  3'd1: dec_uop.op = decode_pkg::SH;
                  3'd2: dec_uop.op = decode_pkg::SW;
                  3'd3: dec_uop.op = decode_pkg::SD;
                  default: ;
               endcase
            end
            decode_pkg::OPC_OP_IMM:
            begin
               dec_uop.dst = rd;
               dec_uop.src_a = rs1;
               dec_uop.dst_valid = (rd != '0);
               dec_uop.src_a_valid = (rd != '0);
               dec_uop.is_int = 1'b1;
               dec_uop.is_cheap_int = 1'b1;
               imm_fmt = decode_pkg::IMM_I;
               case (fetch.insn.i.funct3)
                  3'd0: alu_op = decode_pkg::ADDI;
                  3'd1: alu_op = decode_pkg::SLLI;
                  3'd2: alu_op = decode_pkg::SLTI;
                  3'd3: alu_op = decode_pkg::SLTIU;
                  3'd4: alu_op = decode_pkg::XORI;
                  3'd5:
                  begin
                     if (fetch.insn.r.funct7[6:1] == 6'h00)
                        alu_op = decode_pkg::SRLI;
                     else if (fetch.insn.r.funct7[6:1] == 6'h10)
                        alu_op = decode_pkg::SRAI;
                  end
                  3'd6: alu_op = decode_pkg::ORI;
                  3'd7: alu_op = decode_pkg::ANDI;
               endcase
               dec_uop.op = (alu_op != decode_pkg::II && rd == '0) ? decode_pkg::NOP : alu_op;
            end
            decode_pkg::OPC_OP:
            begin
               dec_uop.dst = rd;
               dec_uop.src_a = rs1;
               dec_uop.src_b = rs2;
               dec_uop.dst_valid = (rd != '0);
               dec_uop.src_a_valid = 1'b1;
               dec_uop.src_b_valid = 1'b1;
               dec_uop.is_int = 1'b1;
               dec_uop.is_cheap_int = (fetch.insn.r.funct7 != 7'h01); // mul/div are slow
               case ({fetch.insn.r.funct7, fetch.insn.r.funct3})
                  {7'h00, 3'd0}: alu_op = decode_pkg::ADDU;
                  {7'h01, 3'd0}: alu_op = decode_pkg::MUL;
                  {7'h20, 3'd0}: alu_op = decode_pkg::SUBU;
                  {7'h00, 3'd1}: alu_op = decode_pkg::SLL;
                  {7'h01, 3'd1}: alu_op = decode_pkg::MULH;
                  {7'h00, 3'd2}: alu_op = decode_pkg::SLT;
                  {7'h00, 3'd3}: alu_op = decode_pkg::SLTU;
                  {7'h01, 3'd3}: alu_op = decode_pkg::MULHU;
                  {7'h00, 3'd4}: alu_op = decode_pkg::XOR;
                  {7'h01, 3'd4}: alu_op = decode_pkg::DIV;
                  {7'h00, 3'd5}: alu_op = decode_pkg::SRL;
                  {7'h01, 3'd5}: alu_op = decode_pkg::DIVU;
                  {7'h20, 3'd5}: alu_op = decode_pkg::SRA;
                  {7'h00, 3'd6}: alu_op = decode_pkg::OR;
                  {7'h01, 3'd6}: alu_op = decode_pkg::REM;
                  {7'h00, 3'd7}: alu_op = decode_pkg::AND;
                  {7'h01, 3'd7}: alu_op = decode_pkg::REMU;
                  default: ;
               endcase
               dec_uop.op = (alu_op != decode_pkg::II && rd == '0) ? decode_pkg::NOP : alu_op;
            end
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC:
            begin
               dec_uop.dst = rd;
               dec_uop.dst_valid = (rd != '0);
               dec_uop.is_int = 1'b1;
               dec_uop.is_cheap_int = 1'b1;
               if (fetch.insn.r.opcode == decode_pkg::OPC_LUI)
               begin
                  alu_op = decode_pkg::LUI;
                  imm_fmt = decode_pkg::IMM_U;
               end
               else
               begin
                  alu_op = decode_pkg::AUIPC;
                  imm_fmt = decode_pkg::IMM_PC_U;
               end
               dec_uop.op = (rd == '0) ? decode_pkg::NOP : alu_op;
            end
            decode_pkg::OPC_MISC_MEM:
               dec_uop.op = decode_pkg::NOP; // fence needs nothing in order
            default: ;
         endcase
      end
      // unused funct codes fall back to a bare II
      if (dec_uop.op == decode_pkg::II)
      begin
         dec_uop = def_uop;
         imm_fmt = decode_pkg::IMM_NONE;
      end
   end

endmodule

// File: source/rv_ctrl_decode.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module rv_ctrl_decode (
   input  decode_pkg::insn_u  insn,
   input  logic               pred,
   input  decode_pkg::xlen_t  pred_target,
   output logic               ctrl_hit,
   output decode_pkg::uop_t   ctrl_uop
);

   decode_pkg::prf_idx_t rd;
   decode_pkg::prf_idx_t rs1;
   decode_pkg::prf_idx_t rs2;
   logic                 rs1_is_link;

   assign rd  = {{(`DEC_LG_PRF-5){1'b0}}, insn.r.rd};
   assign rs1 = {{(`DEC_LG_PRF-5){1'b0}}, insn.r.rs1};
   assign rs2 = {{(`DEC_LG_PRF-5){1'b0}}, insn.r.rs2};

   assign rs1_is_link = (rs1 == `DEC_LINK_RA) || (rs1 == `DEC_LINK_T0);

   always_comb
   begin
      ctrl_hit = 1'b0;
      ctrl_uop = '0;
      ctrl_uop.op = decode_pkg::II;
      case (insn.r.opcode)
         decode_pkg::OPC_BRANCH:
         begin
            ctrl_hit = 1'b1;
            ctrl_uop.src_a = rs1;
            ctrl_uop.src_b = rs2;
            ctrl_uop.src_a_valid = 1'b1;
            ctrl_uop.src_b_valid = 1'b1;
            ctrl_uop.br_pred = pred; // follows the predictor
            ctrl_uop.is_br = 1'b1;
            ctrl_uop.is_int = 1'b1;
            ctrl_uop.is_cheap_int = 1'b1;
            case (insn.b.funct3)
               3'd0: ctrl_uop.op = decode_pkg::BEQ;
               3'd1: ctrl_uop.op = decode_pkg::BNE;
               3'd4: ctrl_uop.op = decode_pkg::BLT;
               3'd5: ctrl_uop.op = decode_pkg::BGE;
               3'd6: ctrl_uop.op = decode_pkg::BLTU;
               3'd7: ctrl_uop.op = decode_pkg::BGEU;
               default: ;
            endcase
         end
         decode_pkg::OPC_JAL:
         begin
            ctrl_hit = 1'b1;
            ctrl_uop.br_pred = 1'b1;
            ctrl_uop.is_br = 1'b1;
            ctrl_uop.is_int = 1'b1;
            if (rd != '0)
            begin
               ctrl_uop.op = decode_pkg::JAL;
               ctrl_uop.dst = rd;
               ctrl_uop.dst_valid = 1'b1;
               ctrl_uop.is_cheap_int = 1'b1;
            end
            else
               ctrl_uop.op = decode_pkg::J;
         end
         decode_pkg::OPC_JALR:
         begin
            ctrl_hit = 1'b1;
            ctrl_uop.src_a = rs1;
            ctrl_uop.src_a_valid = 1'b1;
            ctrl_uop.br_pred = 1'b1;
            ctrl_uop.is_br = 1'b1;
            ctrl_uop.is_int = 1'b1;
            ctrl_uop.is_cheap_int = 1'b1;
            ctrl_uop.imm = pred_target[`DEC_IMM_W-1:0]; // predicted target, low part
            ctrl_uop.jmp_imm = pred_target[`DEC_XLEN-1:`DEC_IMM_W];
            if (rd != '0)
            begin
               ctrl_uop.op = decode_pkg::JALR;
               ctrl_uop.dst = rd;
               ctrl_uop.dst_valid = 1'b1;
            end
            else
               ctrl_uop.op = rs1_is_link ? decode_pkg::RET : decode_pkg::JR;
         end
         default: ;
      endcase
   end

endmodule

// File: source/rv_imm_gen.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module rv_imm_gen (
   input  decode_pkg::insn_u    insn,
   input  decode_pkg::xlen_t    pc,
   input  decode_pkg::imm_fmt_e imm_fmt,
   output decode_pkg::xlen_t    rvimm
);

   decode_pkg::xlen_t imm;
   logic              sign;
   logic              pc_rel;

   assign sign = insn.r.funct7[6]; // insn[31] in every format

   always_comb
   begin
      case (imm_fmt)
         decode_pkg::IMM_I:
            imm = {{(`DEC_XLEN-12){sign}}, insn.i.imm_11_0};
         decode_pkg::IMM_S:
            imm = {{(`DEC_XLEN-12){sign}}, insn.s.imm_11_5, insn.s.imm_4_0};
         decode_pkg::IMM_U,
         decode_pkg::IMM_PC_U:
            imm = {{(`DEC_XLEN-32){sign}}, insn.u.imm_31_12, 12'd0};
         decode_pkg::IMM_PC_B:
            imm = {{(`DEC_XLEN-13){sign}},
                   insn.b.imm_12,
                   insn.b.imm_11,
                   insn.b.imm_10_5,
                   insn.b.imm_4_1,
                   1'b0};
         decode_pkg::IMM_PC_J:
            imm = {{(`DEC_XLEN-21){sign}},
                   insn.j.imm_20,
                   insn.j.imm_19_12,
                   insn.j.imm_11,
                   insn.j.imm_10_1,
                   1'b0};
         default:
            imm = '0;
      endcase
   end

   assign pc_rel = (imm_fmt == decode_pkg::IMM_PC_U) ||
                   (imm_fmt == decode_pkg::IMM_PC_B) ||
                   (imm_fmt == decode_pkg::IMM_PC_J);

   // full 64 bit sum, no truncation
   assign rvimm = pc_rel ? (pc + imm) : imm;

endmodule

// File: source/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

   typedef logic [`DEC_XLEN-1:0]   xlen_t;
   typedef logic [`DEC_LG_PRF-1:0] prf_idx_t;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } insn_r_t;

   typedef struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } insn_i_t;

   typedef struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
   } insn_s_t;

   typedef struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
   } insn_b_t;

   typedef struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } insn_u_t;

   typedef struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } insn_j_t;

   typedef union packed {
      insn_r_t r;
      insn_i_t i;
      insn_s_t s;
      insn_b_t b;
      insn_u_t u;
      insn_j_t j;
   } insn_u;

   typedef enum logic [6:0] {
      OPC_LOAD     = 7'h03,
      OPC_MISC_MEM = 7'h0f,
      OPC_OP_IMM   = 7'h13,
      OPC_AUIPC    = 7'h17,
      OPC_STORE    = 7'h23,
      OPC_OP       = 7'h33,
      OPC_LUI      = 7'h37,
      OPC_BRANCH   = 7'h63,
      OPC_JALR     = 7'h67,
      OPC_JAL      = 7'h6f
   } rv_opcode_e;

   typedef enum logic [6:0] {
      NOP, II, FETCH_PF,
      LB, LH, LW, LD, LBU, LHU, LWU,
      SB, SH, SW, SD,
      ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
      ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      MUL, MULH, MULHU, DIV, DIVU, REM, REMU,
      LUI, AUIPC,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J, JAL, JR, JALR, RET
   } uop_op_e;

   typedef enum logic [2:0] {
      IMM_NONE, IMM_I, IMM_S, IMM_U, IMM_PC_U, IMM_PC_B, IMM_PC_J
   } imm_fmt_e;

   typedef struct packed {
      insn_u insn;
      xlen_t pc;
      logic  page_fault;
      logic  pred;
      xlen_t pred_target;
   } fetch_t;

   typedef struct packed {
      uop_op_e                        op;
      prf_idx_t                       src_a;
      prf_idx_t                       src_b;
      prf_idx_t                       dst;
      logic                           src_a_valid;
      logic                           src_b_valid;
      logic                           dst_valid;
      xlen_t                          rvimm;
      logic [`DEC_IMM_W-1:0]          imm;
      logic [`DEC_XLEN-`DEC_IMM_W-1:0] jmp_imm;
      xlen_t                          pc;
      logic                           br_pred;
      logic                           is_br;
      logic                           is_int;
      logic                           is_cheap_int;
      logic                           is_mem;
      logic                           is_store;
   } uop_t;

endpackage

// File: source/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// machine word and register index widths
`define DEC_XLEN     64
`define DEC_LG_PRF   6

// low part of a predicted jump target kept in uop imm
`define DEC_IMM_W    16

// link registers for call and return detection
`define DEC_LINK_RA  1
`define DEC_LINK_T0  5

`endif
